// ==== hw/rv32_rf_pkg.sv ====
`default_nettype none

package rv32_rf_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_adr_t;

	localparam reg_adr_t reg_x0 = 5'd0;  // hardwired zero register

	// phases of one operand fetch
	typedef enum logic [1:0] {
		rfr_idle = 2'b00,
		rfr_adr  = 2'b01,  // array address is rs1
		rfr_rs1  = 2'b10,  // rs1 data on the read port, address is rs2
		rfr_rs2  = 2'b11   // rs2 data on the read port
	} rfr_state_t;

	typedef enum logic [3:0] {
		op_lui     = 4'd0,
		op_auipc   = 4'd1,
		op_jal     = 4'd2,
		op_jalr    = 4'd3,
		op_branch  = 4'd4,
		op_load    = 4'd5,
		op_store   = 4'd6,
		op_imm     = 4'd7,
		op_reg     = 4'd8,
		op_fence   = 4'd9,
		op_system  = 4'd10,
		op_illegal = 4'd11
	} opcode_t;

	// RV32I major opcode field inst[6:0]
	localparam logic [6:0] rv_op_lui    = 7'b0110111;
	localparam logic [6:0] rv_op_auipc  = 7'b0010111;
	localparam logic [6:0] rv_op_jal    = 7'b1101111;
	localparam logic [6:0] rv_op_jalr   = 7'b1100111;
	localparam logic [6:0] rv_op_branch = 7'b1100011;
	localparam logic [6:0] rv_op_load   = 7'b0000011;
	localparam logic [6:0] rv_op_store  = 7'b0100011;
	localparam logic [6:0] rv_op_imm    = 7'b0010011;
	localparam logic [6:0] rv_op_reg    = 7'b0110011;
	localparam logic [6:0] rv_op_fence  = 7'b0001111;
	localparam logic [6:0] rv_op_system = 7'b1110011;

endpackage

`default_nettype wire

// ==== hw/rf_fetch_ifs.sv ====
`default_nettype none

interface rf_req_if;
	import rv32_rf_pkg::*;

	reg_adr_t rs1_adr;  // forced to x0 when the format does not read rs1
	reg_adr_t rs2_adr;
	opcode_t  opcode;
	logic     req;  // level fetch request

	modport dec (output rs1_adr, output rs2_adr, output opcode, output req);
	modport seq (input rs1_adr, input rs2_adr, input opcode, input req);
endinterface

interface rf_operand_if;
	import rv32_rf_pkg::*;

	rfr_state_t state;
	word_t      rs1_data;
	word_t      rs2_data;
	reg_adr_t   rs1_adr;
	reg_adr_t   rs2_adr;
	logic       rs1_fwd;  // rs1 is live and may take a forwarded writeback
	logic       rs2_fwd;
	opcode_t    opcode;

	modport seq (output state, output rs1_data, output rs2_data, output rs1_adr,
		output rs2_adr, output rs1_fwd, output rs2_fwd, output opcode);
	modport out (input state, input rs1_data, input rs2_data, input rs1_adr,
		input rs2_adr, input rs1_fwd, input rs2_fwd, input opcode);
endinterface

`default_nettype wire

// ==== hw/inst_field_decoder.sv ====
`default_nettype none

module inst_field_decoder (
	input  logic               clk,
	input  logic               rst_n,
	input  rv32_rf_pkg::word_t inst,
	input  logic               issue,
	input  logic               stall,
	rf_req_if.dec              req
);
	import rv32_rf_pkg::*;

	word_t   inst_q;
	logic    req_q;
	opcode_t op;
	logic    use_rs1;
	logic    use_rs2;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			inst_q <= '0;  // decodes as illegal with both sources at x0
			req_q  <= 1'b0;
		end else begin
			req_q <= issue && !stall;
			if (issue && !stall) begin
				inst_q <= inst;
			end
		end
	end

	always_comb begin
		case (inst_q[6:0])
			rv_op_lui:    op = op_lui;
			rv_op_auipc:  op = op_auipc;
			rv_op_jal:    op = op_jal;
			rv_op_jalr:   op = op_jalr;
			rv_op_branch: op = op_branch;
			rv_op_load:   op = op_load;
			rv_op_store:  op = op_store;
			rv_op_imm:    op = op_imm;
			rv_op_reg:    op = op_reg;
			rv_op_fence:  op = op_fence;
			rv_op_system: op = op_system;
			default:      op = op_illegal;
		endcase
	end

	// which source fields the format really reads
	always_comb begin
		case (op)
			op_jalr, op_load, op_imm, op_system: begin
				use_rs1 = 1'b1;  // I-type reads rs1 only, csr ops included
				use_rs2 = 1'b0;
			end
			op_branch, op_store, op_reg: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			default: begin
				use_rs1 = 1'b0;  // U and J types, fence and illegal read nothing
				use_rs2 = 1'b0;
			end
		endcase
	end

	assign req.rs1_adr = use_rs1 ? inst_q[19:15] : reg_x0;
	assign req.rs2_adr = use_rs2 ? inst_q[24:20] : reg_x0;
	assign req.opcode  = op;
	assign req.req     = req_q;

endmodule

`default_nettype wire

// ==== hw/rf_read_seq.sv ====
`default_nettype none

module rf_read_seq (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall,
	rf_req_if.seq                 req,
	output rv32_rf_pkg::reg_adr_t ram_adr,
	input  rv32_rf_pkg::word_t    ram_data,
	output logic                  rfr_run,
	rf_operand_if.seq             opnd
);
	import rv32_rf_pkg::*;

	rfr_state_t state;
	rfr_state_t state_nxt;
	logic       start;
	reg_adr_t   rs1_adr_q;
	reg_adr_t   rs2_adr_q;
	opcode_t    opcode_q;
	logic       rs1_live;
	logic       rs2_live;
	word_t      rs1_q;
	word_t      rs2_q;

	always_comb begin
		case (state)
			rfr_idle: state_nxt = (req.req && !stall) ? rfr_adr : rfr_idle;
			rfr_adr:  state_nxt = stall ? rfr_idle : rfr_rs1;  // stall aborts the fetch
			rfr_rs1:  state_nxt = stall ? rfr_idle : rfr_rs2;
			rfr_rs2:  state_nxt = rfr_idle;  // rs2 is on the port so stall no longer matters
			default:  state_nxt = rfr_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= rfr_idle;
		end else begin
			state <= state_nxt;
		end
	end

	assign start   = (state == rfr_idle) && (state_nxt == rfr_adr);
	assign rfr_run = (state != rfr_idle);

	// the request fields are held for the whole fetch
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rs1_adr_q <= reg_x0;
			rs2_adr_q <= reg_x0;
			opcode_q  <= op_illegal;
		end else if (start) begin
			rs1_adr_q <= req.rs1_adr;
			rs2_adr_q <= req.rs2_adr;
			opcode_q  <= req.opcode;
		end
	end

	assign ram_adr  = (state == rfr_adr) ? rs1_adr_q : rs2_adr_q;
	assign rs1_live = (rs1_adr_q != reg_x0);
	assign rs2_live = (rs2_adr_q != reg_x0);

	// each operand is taken from the read port one cycle after its address
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rs1_q <= '0;
			rs2_q <= '0;
		end else begin
			if (state == rfr_rs1) begin
				rs1_q <= rs1_live ? ram_data : '0;  // x0 always reads zero
			end
			if (state == rfr_rs2) begin
				rs2_q <= rs2_live ? ram_data : '0;
			end
		end
	end

	assign opnd.state    = state;
	assign opnd.rs1_data = rs1_q;
	assign opnd.rs2_data = rs2_q;
	assign opnd.rs1_adr  = rs1_adr_q;
	assign opnd.rs2_adr  = rs2_adr_q;
	assign opnd.rs1_fwd  = rs1_live;
	assign opnd.rs2_fwd  = rs2_live;
	assign opnd.opcode   = opcode_q;

endmodule

`default_nettype wire

// ==== hw/rf_1r1w.sv ====
`default_nettype none

module rf_1r1w (
	input  logic                  clk,
	input  rv32_rf_pkg::reg_adr_t radr,
	output rv32_rf_pkg::word_t    rdata,
	input  rv32_rf_pkg::reg_adr_t wadr,
	input  rv32_rf_pkg::word_t    wdata,
	input  logic                  wen
);
	import rv32_rf_pkg::*;

	word_t mem [32];

	always_ff @(posedge clk) begin
		if (wen) begin
			mem[wadr] <= wdata;
		end
	end

	// read sees the old entry when the same address is written on this edge
	always_ff @(posedge clk) begin
		rdata <= mem[radr];
	end

endmodule

`default_nettype wire

// ==== hw/operand_out.sv ====
`default_nettype none

module operand_out (
	input  logic                  clk,
	input  logic                  rst_n,
	rf_operand_if.out             opnd,
	input  logic                  wb_en,
	input  rv32_rf_pkg::reg_adr_t wb_adr,
	input  rv32_rf_pkg::word_t    wb_data,
	output rv32_rf_pkg::word_t    rs1_data,
	output rv32_rf_pkg::word_t    rs2_data,
	output rv32_rf_pkg::opcode_t  opcode,
	output logic                  operand_valid
);
	import rv32_rf_pkg::*;

	logic  busy;
	logic  rs1_hit;
	logic  rs2_hit;
	logic  rs1_pend;
	logic  rs2_pend;
	word_t rs1_fwd_val;
	word_t rs2_fwd_val;
	logic  done_q;

	// writebacks the array read may have missed are tracked while a fetch runs
	assign busy    = (opnd.state != rfr_idle);
	assign rs1_hit = wb_en && opnd.rs1_fwd && (wb_adr == opnd.rs1_adr);
	assign rs2_hit = wb_en && opnd.rs2_fwd && (wb_adr == opnd.rs2_adr);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rs1_pend <= 1'b0;
			rs2_pend <= 1'b0;
		end else if (!busy) begin
			rs1_pend <= 1'b0;  // an aborted fetch leaves nothing behind
			rs2_pend <= 1'b0;
		end else begin
			if (rs1_hit) begin
				rs1_pend <= 1'b1;
			end
			if (rs2_hit) begin
				rs2_pend <= 1'b1;
			end
		end
	end

	// the last matching write wins
	always_ff @(posedge clk) begin
		if (busy && rs1_hit) begin
			rs1_fwd_val <= wb_data;
		end
		if (busy && rs2_hit) begin
			rs2_fwd_val <= wb_data;
		end
	end

	// rs2 is captured on the edge that leaves rfr_rs2 so results follow one cycle later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done_q <= 1'b0;
		end else begin
			done_q <= (opnd.state == rfr_rs2);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rs1_data      <= '0;
			rs2_data      <= '0;
			opcode        <= op_lui;  // encodes as zero
			operand_valid <= 1'b0;
		end else begin
			operand_valid <= done_q;  // one-cycle pulse
			if (done_q) begin
				rs1_data <= rs1_pend ? rs1_fwd_val : opnd.rs1_data;
				rs2_data <= rs2_pend ? rs2_fwd_val : opnd.rs2_data;
				opcode   <= opnd.opcode;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/rf_fetch_top.sv ====
`default_nettype none

module rf_fetch_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv32_rf_pkg::word_t    inst,
	input  logic                  issue,
	input  logic                  stall,
	input  logic                  wb_en,
	input  rv32_rf_pkg::reg_adr_t wb_adr,
	input  rv32_rf_pkg::word_t    wb_data,
	output rv32_rf_pkg::word_t    rs1_data,
	output rv32_rf_pkg::word_t    rs2_data,
	output rv32_rf_pkg::opcode_t  opcode,
	output logic                  operand_valid,
	output logic                  rfr_run
);
	import rv32_rf_pkg::*;

	reg_adr_t ram_adr;
	word_t    ram_data;

	rf_req_if     req_if ();
	rf_operand_if opnd_if ();

	inst_field_decoder inst_field_decoder_i (
		.clk   (clk),
		.rst_n (rst_n),
		.inst  (inst),
		.issue (issue),
		.stall (stall),
		.req   (req_if.dec)
	);

	rf_read_seq rf_read_seq_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.stall    (stall),
		.req      (req_if.seq),
		.ram_adr  (ram_adr),
		.ram_data (ram_data),
		.rfr_run  (rfr_run),
		.opnd     (opnd_if.seq)
	);

	// writeback goes straight into the array and also to the forwarding stage
	rf_1r1w rf_1r1w_i (
		.clk   (clk),
		.radr  (ram_adr),
		.rdata (ram_data),
		.wadr  (wb_adr),
		.wdata (wb_data),
		.wen   (wb_en)
	);

	operand_out operand_out_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.opnd          (opnd_if.out),
		.wb_en         (wb_en),
		.wb_adr        (wb_adr),
		.wb_data       (wb_data),
		.rs1_data      (rs1_data),
		.rs2_data      (rs2_data),
		.opcode        (opcode),
		.operand_valid (operand_valid)
	);

endmodule

`default_nettype wire

// ==== testbench/rf_fetch_tb.sv ====
`default_nettype none

module rf_fetch_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int max_vec  = 64;
	localparam int clk_half = 2;

	logic        clk;
	logic        rst_n;
	logic [31:0] inst;
	logic        issue;
	logic        stall;
	logic        wb_en;
	logic [4:0]  wb_adr;
	logic [31:0] wb_data;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic [3:0]  opcode;
	logic        operand_valid;
	logic        rfr_run;

	// one entry per vector line where write lines use only v_adr and v_word
	logic [7:0]  v_kind    [max_vec];
	logic [31:0] v_word    [max_vec];  // instruction or the data of a write line
	int          v_adr     [max_vec];
	int          v_stall   [max_vec];  // edge after E that sees stall or -1 for none
	int          v_wb_off  [max_vec];
	int          v_wb_adr  [max_vec];
	logic [31:0] v_wb_data [max_vec];
	int          v_op      [max_vec];
	logic [31:0] v_rs1     [max_vec];
	logic [31:0] v_rs2     [max_vec];
	int          n_vec;
	int          limit  = 0;
	int          cycles = 0;

	rf_fetch_top rf_fetch_top_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.inst          (inst),
		.issue         (issue),
		.stall         (stall),
		.wb_en         (wb_en),
		.wb_adr        (wb_adr),
		.wb_data       (wb_data),
		.rs1_data      (rs1_data),
		.rs2_data      (rs2_data),
		.opcode        (opcode),
		.operand_valid (operand_valid),
		.rfr_run       (rfr_run)
	);

	initial begin
		clk = 1'b0;
		forever #clk_half clk = ~clk;
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_word(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else
			stop_with_failure($sformatf("error at %0d ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic read_vectors();
		int         fd;
		int         ch;
		int         got;
		logic [7:0] kind;
		n_vec = 0;
		fd = $fopen("testbench/rf_fetch_vectors.txt", "r");
		if (fd == 0) begin
			stop_with_failure("the vector file testbench/rf_fetch_vectors.txt could not be opened");
		end else begin
			got = $fscanf(fd, " %c", kind);
			while (got == 1) begin
				if (kind == "#") begin
					ch = $fgetc(fd);  // skip the rest of a comment line
					while (ch != "\n" && ch != -1) begin
						ch = $fgetc(fd);
					end
				end else if (kind == "W") begin
					got = $fscanf(fd, "%d %h", v_adr[n_vec], v_word[n_vec]);
					v_kind[n_vec] = kind;
					n_vec++;
				end else begin
					got = $fscanf(fd, "%h %d %d %d %h %d %h %h", v_word[n_vec],
						v_stall[n_vec], v_wb_off[n_vec], v_wb_adr[n_vec],
						v_wb_data[n_vec], v_op[n_vec], v_rs1[n_vec], v_rs2[n_vec]);
					v_kind[n_vec] = kind;
					n_vec++;
				end
				got = $fscanf(fd, " %c", kind);
			end
			$fclose(fd);
		end
	endtask

	// inputs that the edge E+k samples are driven one edge earlier
	task automatic drive_fetch_inputs(input int i, input int k);
		stall   <= (v_stall[i] == k);
		wb_en   <= (v_wb_off[i] == k);
		wb_adr  <= 5'(v_wb_adr[i]);
		wb_data <= v_wb_data[i];
	endtask

	task automatic write_reg(input int i);
		@(posedge clk);
		wb_en   <= 1'b1;
		wb_adr  <= 5'(v_adr[i]);
		wb_data <= v_word[i];
		@(posedge clk);
		wb_en <= 1'b0;
	endtask

	task automatic run_issue(input int i);
		int c;
		int run_end;
		bit abort_exp;
		bit ran;
		bit finished;
		bit run_exp;
		abort_exp = (v_stall[i] == 2) || (v_stall[i] == 3);  // stall in rfr_adr or rfr_rs1
		run_end   = abort_exp ? v_stall[i] : 4;  // edge E+k that returns the FSM to idle
		ran       = 1'b0;
		finished  = 1'b0;
		c         = 0;
		@(posedge clk);
		inst  <= v_word[i];
		issue <= 1'b1;
		drive_fetch_inputs(i, 0);
		while (!finished) begin
			@(posedge clk);  // edge E+c where E is the edge that samples issue
			issue <= 1'b0;
			drive_fetch_inputs(i, c + 1);
			@(negedge clk);
			run_exp = (c >= 1) && (c < run_end);
			assert (rfr_run === run_exp) else
				stop_with_failure($sformatf("error at %0d ns: vector %0d rfr_run %b, expected %b",
					$time, i, rfr_run, run_exp));
			if (rfr_run) begin
				ran = 1'b1;
			end
			if (abort_exp) begin
				assert (!operand_valid) else
					stop_with_failure($sformatf("error at %0d ns: vector %0d aborted but %s",
						$time, i, "operand_valid rose"));
				finished = ran && !rfr_run;
			end else if (operand_valid) begin
				assert (c == 5) else
					stop_with_failure($sformatf("error at %0d ns: vector %0d valid %0d %s",
						$time, i, c, "cycles after issue, expected 5"));
				check_word($sformatf("vector %0d opcode", i), 32'(opcode), 32'(v_op[i]));
				check_word($sformatf("vector %0d rs1_data", i), rs1_data, v_rs1[i]);
				check_word($sformatf("vector %0d rs2_data", i), rs2_data, v_rs2[i]);
				finished = 1'b1;
			end
			c++;
		end
		// the pulse lasts one cycle and an aborted fetch stays silent
		repeat (abort_exp ? 4 : 1) begin
			@(posedge clk);
			drive_fetch_inputs(i, c + 1);
			@(negedge clk);
			assert (!operand_valid) else
				stop_with_failure($sformatf("error at %0d ns: vector %0d operand_valid %s",
					$time, i, "high in an extra cycle"));
			c++;
		end
	endtask

	initial begin
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		stop_with_failure($sformatf("timeout: operand_valid never arrived within %0d cycles",
			limit));
	end

	initial begin
		int i;
		rst_n   = 1'b0;
		inst    = '0;
		issue   = 1'b0;
		stall   = 1'b0;
		wb_en   = 1'b0;
		wb_adr  = '0;
		wb_data = '0;
		read_vectors();
		limit = n_vec * 12 + 100;
		repeat (15) @(posedge clk);
		@(negedge clk);
		check_word("rs1_data in reset", rs1_data, 32'h0);
		check_word("rs2_data in reset", rs2_data, 32'h0);
		check_word("opcode in reset", 32'(opcode), 32'h0);
		check_word("operand_valid in reset", 32'(operand_valid), 32'h0);
		check_word("rfr_run in reset", 32'(rfr_run), 32'h0);
		@(posedge clk);
		rst_n <= 1'b1;
		for (i = 0; i < n_vec; i++) begin
			if (v_kind[i] == "W") begin
				write_reg(i);
			end else begin
				run_issue(i);
			end
		end
		repeat (2) @(posedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rf_fetch.f ====
hw/rv32_rf_pkg.sv
hw/rf_fetch_ifs.sv
hw/inst_field_decoder.sv
hw/rf_read_seq.sv
hw/rf_1r1w.sv
hw/operand_out.sv
hw/rf_fetch_top.sv
testbench/rf_fetch_tb.sv

// ==== Bender.yml ====
package:
  name: rf_fetch

sources:
  - files:
      - hw/rv32_rf_pkg.sv
      - hw/rf_fetch_ifs.sv
      - hw/inst_field_decoder.sv
      - hw/rf_read_seq.sv
      - hw/rf_1r1w.sv
      - hw/operand_out.sv
      - hw/rf_fetch_top.sv
  - target: test
    files:
      - testbench/rf_fetch_tb.sv

// ==== testbench/rf_fetch_vectors.txt ====
# W <reg dec> <data hex> writes a register through the writeback port
# I <inst hex> <stall off> <wb off> <wb reg> <wb data hex> <opcode dec> <rs1 hex> <rs2 hex>
# offsets count edges after the one that samples issue, -1 means none
# a stall at offset 2 or 3 aborts the fetch and its expected values are unused
W 1 11111111
W 2 22222222
W 3 33333333
W 5 55555555
W 6 66666666
W 7 77777777
W 8 88888888
# add x4, x1, x2
I 00208233 -1 -1 0 00000000 8 11111111 22222222
# lw x8, 5(x3) and addi x9, x6, 7 with live registers in the rs2 field
I 0051a403 -1 -1 0 00000000 5 33333333 00000000
I 00730493 -1 -1 0 00000000 7 66666666 00000000
# lui x10, 0x12345 has x8 and x3 in its source fields
I 12345537 -1 -1 0 00000000 0 00000000 00000000
I 00518063 -1 -1 0 00000000 4 33333333 55555555
I 000300e7 -1 -1 0 00000000 3 66666666 00000000
I 0080006f -1 -1 0 00000000 2 00000000 00000000
# x0 stays zero after writes to it
W 0 deadbeef
I 0000a223 -1 -1 0 00000000 6 11111111 00000000
I 002005b3 -1 2 0 cafef00d 8 00000000 22222222
# add x12, x1, x2 with a writeback inside the fetch window
I 00208633 -1 1 1 a1a1a1a1 8 a1a1a1a1 22222222
I 00208633 -1 2 2 b2b2b2b2 8 a1a1a1a1 b2b2b2b2
I 00208633 -1 3 1 c3c3c3c3 8 c3c3c3c3 b2b2b2b2
I 00208633 -1 4 2 d4d4d4d4 8 c3c3c3c3 d4d4d4d4
I 00208633 -1 3 7 77770000 8 c3c3c3c3 d4d4d4d4
# a write at offset 5 lands after the window
I 00208633 -1 5 1 e5e5e5e5 8 c3c3c3c3 d4d4d4d4
I 00208633 -1 -1 0 00000000 8 e5e5e5e5 d4d4d4d4
# stall in rfr_adr, in rfr_rs1, then in rfr_rs2 where it is ignored
I 00208633 2 -1 0 00000000 0 00000000 00000000
I 00208633 -1 -1 0 00000000 8 e5e5e5e5 d4d4d4d4
I 00208633 3 -1 0 00000000 0 00000000 00000000
I 00208633 -1 -1 0 00000000 8 e5e5e5e5 d4d4d4d4
I 00208633 4 -1 0 00000000 8 e5e5e5e5 d4d4d4d4
# unknown major opcodes
I ffffffff -1 -1 0 00000000 11 00000000 00000000
I 0020810b -1 -1 0 00000000 11 00000000 00000000
